/* design/imu_bridge_defs.svh */
`ifndef IMU_BRIDGE_DEFS_SVH
`define IMU_BRIDGE_DEFS_SVH

// Frame layout
`define IMU_HEADER_BYTE 8'hAA  // First byte of every frame
`define IMU_FRAME_BYTES 16     // Header, six words, flags, drops, seq

// Sample queue
`define IMU_QUEUE_DEPTH 4      // Entries, need not be a power of two

// SPI timing in system clocks
`define IMU_SPI_QUARTER 2      // Clocks per quarter SCK period

// Phase lengths in quarter periods
`define IMU_LEAD_QUARTERS  8   // cs_n low before first bit
`define IMU_TRAIL_QUARTERS 4   // After last sck fall, before cs_n rise

// cs_n high before packet_sent
// Sized so cs_n fall to packet_sent is 548 quarters
`define IMU_GAP_QUARTERS   24

`endif

/* design/imu_bridge_pkg.sv */
package imu_bridge_pkg;

    // Sample as strobed in by the host
    typedef struct packed {
        logic signed [15:0] roll;    // Euler angles
        logic signed [15:0] pitch;
        logic signed [15:0] yaw;
        logic signed [15:0] gyro_x;  // Body rates
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
        logic               euler_valid;
        logic               gyro_valid;
    } imu_raw_t;                     // 98 bits

    // Queue entry, raw sample plus capture stamps
    typedef struct packed {
        logic signed [15:0] roll;
        logic signed [15:0] pitch;
        logic signed [15:0] yaw;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
        logic               euler_valid;
        logic               gyro_valid;
        logic        [7:0]  drop_count;  // Saturating drops so far
        logic        [7:0]  seq;         // Accepted sample number

    } imu_sample_t;                      // 114 bits

    // Frame flags byte
    // bit 1 gyro_valid and bit 0 euler_valid

endpackage

/* design/sample_capture.sv */
`timescale 1ns/1ps

module sample_capture (
    input  logic                        send_packet,   // System clock
    input  logic                        rst_n,
    input  logic                        sample_strobe, // One-cycle host pulse
    input  imu_bridge_pkg::imu_raw_t    raw,
    input  logic                        full,          // From queue
    output logic                        wr_en,
    output imu_bridge_pkg::imu_sample_t wr_data
);
    import imu_bridge_pkg::*;

    imu_raw_t   raw_q;      // Latched sample
    logic       pend_q;     // Sample waiting for write/drop decision
    logic [7:0] seq_q;
    logic [7:0] drop_q;
    logic       accept;

    // Latch on strobe, payload has no reset
    always_ff @(posedge send_packet) begin
        if (sample_strobe) begin
            raw_q <= raw;
        end
    end

    // Decision one cycle after strobe
    // full already reflects every earlier write here
    assign accept = pend_q && !full;
    assign wr_en  = accept;

    always_ff @(posedge send_packet) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            seq_q  <= 8'd0;
            drop_q <= 8'd0;
        end else begin
            pend_q <= sample_strobe;  // Back-to-back strobes keep it high
            if (accept) begin
                seq_q <= seq_q + 8'd1;                 // Wraps at 256
            end else if (pend_q && drop_q != 8'hFF) begin
                drop_q <= drop_q + 8'd1;               // Queue full, sample lost
            end
        end
    end

    // Queue entry with current stamps
    always_comb begin
        wr_data.roll        = raw_q.roll;
        wr_data.pitch       = raw_q.pitch;
        wr_data.yaw         = raw_q.yaw;
        wr_data.gyro_x      = raw_q.gyro_x;
        wr_data.gyro_y      = raw_q.gyro_y;
        wr_data.gyro_z      = raw_q.gyro_z;
        wr_data.euler_valid = raw_q.euler_valid;
        wr_data.gyro_valid  = raw_q.gyro_valid;
        wr_data.drop_count  = drop_q;  // Drops before this sample
        wr_data.seq         = seq_q;
    end

endmodule

/* design/sample_queue.sv */
`timescale 1ns/1ps
`include "imu_bridge_defs.svh"

module sample_queue (
    input  logic                        send_packet,  // System clock
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  imu_bridge_pkg::imu_sample_t wr_data,
    input  logic                        rd_en,
    output imu_bridge_pkg::imu_sample_t rd_data,      // Head entry, always shown
    output logic                        full,
    output logic                        empty
);
    import imu_bridge_pkg::*;

    localparam int DEPTH = `IMU_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);  // Holds 0..DEPTH

    imu_sample_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // Occupancy
    logic             do_wr;
    logic             do_rd;

    // Wrap at DEPTH-1 so odd depths work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr = wr_en && !full;   // Guards against misuse
    assign do_rd = rd_en && !empty;

    // Storage
    always_ff @(posedge send_packet) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge send_packet) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or write plus read
            endcase
        end
    end

    // Flags straight from occupancy
    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];  // Fall-through head

endmodule

/* design/spi_frame_tx.sv */
`timescale 1ns/1ps
`include "imu_bridge_defs.svh"

module spi_frame_tx (
    input  logic                        send_packet,  // System clock
    input  logic                        rst_n,
    input  logic                        empty,        // Queue empty flag
    input  imu_bridge_pkg::imu_sample_t rd_data,      // Queue head
    output logic                        rd_en,
    output logic                        cs_n,
    output logic                        sck,
    output logic                        sdi,          // MOSI
    output logic                        packet_sent
);
    import imu_bridge_pkg::*;

    localparam int Q          = `IMU_SPI_QUARTER;
    localparam int LEAD_CLKS  = `IMU_LEAD_QUARTERS * Q;
    localparam int BIT_CLKS   = 4 * Q;                 // One SCK period
    localparam int TRAIL_CLKS = `IMU_TRAIL_QUARTERS * Q;
    localparam int GAP_CLKS   = `IMU_GAP_QUARTERS * Q;
    localparam int MAX_A      = (LEAD_CLKS > TRAIL_CLKS) ? LEAD_CLKS : TRAIL_CLKS;
    localparam int MAX_B      = (GAP_CLKS > BIT_CLKS) ? GAP_CLKS : BIT_CLKS;
    localparam int MAX_CLKS   = (MAX_A > MAX_B) ? MAX_A : MAX_B;
    localparam int CNT_W      = $clog2(MAX_CLKS);
    localparam int BYTE_W     = $clog2(`IMU_FRAME_BYTES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LEAD,   // cs_n low, sck low
        ST_BITS,
        ST_TRAIL,
        ST_GAP,    // cs_n high again
        ST_DONE    // packet_sent high
    } phase_t;

    phase_t            state;
    logic [CNT_W-1:0]  cnt;       // Clocks within phase or bit
    logic [2:0]        bit_cnt;   // Current bit, 7 down to 0
    logic [BYTE_W-1:0] byte_idx;
    imu_sample_t       smp_q;     // Sample being sent
    logic [7:0]        cur_byte;
    logic [7:0]        nxt_byte;

    // Frame byte rule, words big-endian
    function automatic logic [7:0] frame_byte(input imu_sample_t s,
                                              input logic [BYTE_W-1:0] idx);
        logic [7:0] b;
        case (idx)
            0:       b = `IMU_HEADER_BYTE;
            1:       b = s.roll[15:8];
            2:       b = s.roll[7:0];
            3:       b = s.pitch[15:8];
            4:       b = s.pitch[7:0];
            5:       b = s.yaw[15:8];
            6:       b = s.yaw[7:0];
            7:       b = s.gyro_x[15:8];
            8:       b = s.gyro_x[7:0];
            9:       b = s.gyro_y[15:8];
            10:      b = s.gyro_y[7:0];
            11:      b = s.gyro_z[15:8];
            12:      b = s.gyro_z[7:0];
            13:      b = {6'd0, s.gyro_valid, s.euler_valid};  // Flags
            14:      b = s.drop_count;
            default: b = s.seq;                                // Byte 15
        endcase
        return b;
    endfunction

    assign cur_byte = frame_byte(smp_q, byte_idx);
    assign nxt_byte = frame_byte(smp_q, byte_idx + 1'b1);

    // Pop head while idle, data valid this cycle
    assign rd_en = (state == ST_IDLE) && !empty;

    always_ff @(posedge send_packet) begin
        if (rd_en) begin
            smp_q <= rd_data;
        end
    end

    always_ff @(posedge send_packet) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            bit_cnt     <= 3'd7;
            byte_idx    <= '0;
            cs_n        <= 1'b1;
            sck         <= 1'b0;
            sdi         <= 1'b0;
            packet_sent <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;  // Default, phases clear it at their end
            case (state)
                ST_IDLE: begin
                    cnt      <= '0;
                    byte_idx <= '0;
                    bit_cnt  <= 3'd7;
                    if (!empty) begin
                        cs_n  <= 1'b0;      // Falls cycle after rd_en
                        state <= ST_LEAD;
                    end
                end
                ST_LEAD: if (cnt == CNT_W'(LEAD_CLKS - 1)) begin
                    cnt   <= '0;
                    sdi   <= cur_byte[7];   // Header MSB
                    state <= ST_BITS;
                end
                ST_BITS: begin
                    if (cnt == CNT_W'(Q - 1)) begin
                        sck <= 1'b1;        // Slave samples here
                    end
                    if (cnt == CNT_W'(3 * Q - 1)) begin
                        sck <= 1'b0;
                    end
                    if (cnt == CNT_W'(BIT_CLKS - 1)) begin
                        cnt <= '0;
                        if (bit_cnt != 3'd0) begin
                            bit_cnt <= bit_cnt - 3'd1;
                            sdi     <= cur_byte[bit_cnt - 3'd1];
                        end else if (byte_idx == BYTE_W'(`IMU_FRAME_BYTES - 1)) begin
                            sdi   <= 1'b0;  // Last bit done
                            state <= ST_TRAIL;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            bit_cnt  <= 3'd7;
                            sdi      <= nxt_byte[7];
                        end
                    end
                end
                ST_TRAIL: if (cnt == CNT_W'(TRAIL_CLKS - 1)) begin
                    cnt   <= '0;
                    cs_n  <= 1'b1;
                    state <= ST_GAP;
                end
                ST_GAP: if (cnt == CNT_W'(GAP_CLKS - 1)) begin
                    packet_sent <= 1'b1;
                    state       <= ST_DONE;
                end
                default: begin              // ST_DONE, single-cycle pulse
                    packet_sent <= 1'b0;
                    state       <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/imu_spi_bridge.sv */
`timescale 1ns/1ps

module imu_spi_bridge (
    input  logic               send_packet,    // System clock
    input  logic               rst_n,          // Sync, active low
    input  logic               sample_strobe,
    input  logic signed [15:0] roll,
    input  logic signed [15:0] pitch,
    input  logic signed [15:0] yaw,
    input  logic signed [15:0] gyro_x,
    input  logic signed [15:0] gyro_y,
    input  logic signed [15:0] gyro_z,
    input  logic               euler_valid,
    input  logic               gyro_valid,
    output logic               cs_n,
    output logic               sck,
    output logic               sdi,
    output logic               packet_sent
);
    import imu_bridge_pkg::*;

    imu_raw_t    raw;
    imu_sample_t wr_data;
    imu_sample_t rd_data;
    logic        wr_en;
    logic        rd_en;
    logic        full;
    logic        empty;

    // Host pins into one bundle
    assign raw = '{roll: roll, pitch: pitch, yaw: yaw,
                   gyro_x: gyro_x, gyro_y: gyro_y, gyro_z: gyro_z,
                   euler_valid: euler_valid, gyro_valid: gyro_valid};

    sample_capture sample_capture_inst (
        .send_packet(send_packet), .rst_n(rst_n), .sample_strobe(sample_strobe),
        .raw(raw), .full(full), .wr_en(wr_en), .wr_data(wr_data)
    );

    sample_queue sample_queue_inst (
        .send_packet(send_packet), .rst_n(rst_n),
        .wr_en(wr_en), .wr_data(wr_data),
        .rd_en(rd_en), .rd_data(rd_data),
        .full(full), .empty(empty)
    );

    // Frame serializer
    spi_frame_tx spi_frame_tx_inst (
        .send_packet(send_packet), .rst_n(rst_n),
        .empty(empty), .rd_data(rd_data), .rd_en(rd_en),
        .cs_n(cs_n), .sck(sck), .sdi(sdi), .packet_sent(packet_sent)
    );

endmodule

/* dv/imu_spi_bridge_tb.sv */
`timescale 1ns/1ps
`include "imu_bridge_defs.svh"

module imu_spi_bridge_tb;
    import imu_bridge_pkg::*;

    localparam int COLS         = 12;    // Hex words per trace line
    localparam int MAX_LINES    = 32;
    localparam int FRAME_CYCLES = 1096;  // cs_n fall to packet_sent
    localparam int FRAME_BITS   = 8 * `IMU_FRAME_BYTES;

    logic               send_packet = 1'b0;
    logic               rst_n;
    logic               sample_strobe;
    logic signed [15:0] roll;
    logic signed [15:0] pitch;
    logic signed [15:0] yaw;
    logic signed [15:0] gyro_x;
    logic signed [15:0] gyro_y;
    logic signed [15:0] gyro_z;
    logic               euler_valid;
    logic               gyro_valid;
    logic               cs_n;
    logic               sck;
    logic               sdi;
    logic               packet_sent;

    logic [31:0]     trace_mem [COLS*MAX_LINES];
    imu_sample_t     exp_mem [256];          // Accepted samples in strobe order
    integer          seed = 32'h66ea_1db9;
    int              accepted_total = 0;     // Written by stimulus only
    logic [7:0]      exp_seq = 8'd0;
    logic [7:0]      exp_drops = 8'd0;
    int              main_errors = 0;
    int              watch_cycles = 0;
    int              tests_ok = 0;
    int              tests_bad = 0;

    // Monitor state, written by the monitor only
    int                    mon_errors = 0;
    int                    cyc = 0;
    int                    start_cyc = 0;
    int                    frames_started = 0;
    int                    frames_checked = 0;
    int                    sent_cnt = 0;
    int                    ps_len = 0;
    int                    rx_count = 0;
    logic [FRAME_BITS-1:0] rx_bits = '0;
    logic                  prev_cs = 1'b1;
    logic                  prev_sck = 1'b0;

    imu_spi_bridge imu_spi_bridge_inst (
        .send_packet(send_packet), .rst_n(rst_n), .sample_strobe(sample_strobe),
        .roll(roll), .pitch(pitch), .yaw(yaw),
        .gyro_x(gyro_x), .gyro_y(gyro_y), .gyro_z(gyro_z),
        .euler_valid(euler_valid), .gyro_valid(gyro_valid),
        .cs_n(cs_n), .sck(sck), .sdi(sdi), .packet_sent(packet_sent)
    );

    always #50 send_packet = ~send_packet;  // 100 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int err_cnt);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // Header, six words high byte first, flags, drops, seq
    function automatic logic [FRAME_BITS-1:0] expected_frame(input imu_sample_t s);
        return {`IMU_HEADER_BYTE, s.roll, s.pitch, s.yaw, s.gyro_x, s.gyro_y, s.gyro_z,
                6'd0, s.gyro_valid, s.euler_valid, s.drop_count, s.seq};
    endfunction

    task automatic check_frame();
        logic [FRAME_BITS-1:0] want;
        int                    b;
        if (frames_checked >= accepted_total) begin
            $display("error: a frame was sent while no sample was expected at %0t", $time);
            mon_errors++;
        end else begin
            want = expected_frame(exp_mem[frames_checked]);
            check_value("sck rising edges", 32'(rx_count), 32'(FRAME_BITS), mon_errors);
            for (b = 0; b < `IMU_FRAME_BYTES; b++) begin
                check_value($sformatf("frame %0d byte %0d", frames_checked, b),
                            32'(rx_bits[FRAME_BITS-1-8*b -: 8]),
                            32'(want[FRAME_BITS-1-8*b -: 8]), mon_errors);
            end
            frames_checked++;
        end
    endtask

    // Frame decoder and timing monitor, outputs are stable at the clock fall
    always @(negedge send_packet) begin
        cyc++;
        if (rst_n === 1'b1) begin
            if (prev_cs === 1'b1 && cs_n === 1'b0) begin  // Frame start
                start_cyc = cyc;
                frames_started++;
                rx_count  = 0;
                rx_bits   = '0;
            end
            if (cs_n === 1'b0 && sck === 1'b1 && prev_sck === 1'b0) begin
                rx_bits = {rx_bits[FRAME_BITS-2:0], sdi};  // sdi held through sck high
                rx_count++;
            end
            if (prev_cs === 1'b0 && cs_n === 1'b1) begin
                check_frame();
            end
            if (packet_sent === 1'b1) begin
                if (ps_len == 0) begin
                    check_value("cs_n at packet_sent", 32'(cs_n), 32'h1, mon_errors);
                    check_value("cs_n fall to packet_sent", 32'(cyc - start_cyc),
                                32'(FRAME_CYCLES), mon_errors);
                    sent_cnt++;
                end
                ps_len++;
            end else if (ps_len != 0) begin
                check_value("packet_sent cycles high", 32'(ps_len), 32'h1, mon_errors);
                ps_len = 0;
            end
        end
        prev_cs  = cs_n;
        prev_sck = sck;
    end

    // Reference model, the bridge holds queue depth plus one samples
    task automatic model_capture(input imu_raw_t r);
        if (accepted_total - sent_cnt < `IMU_QUEUE_DEPTH + 1) begin
            exp_mem[accepted_total] = '{roll: r.roll, pitch: r.pitch, yaw: r.yaw,
                                        gyro_x: r.gyro_x, gyro_y: r.gyro_y, gyro_z: r.gyro_z,
                                        euler_valid: r.euler_valid, gyro_valid: r.gyro_valid,
                                        drop_count: exp_drops, seq: exp_seq};
            exp_seq++;           // Wraps at 256
            accepted_total++;
        end else if (exp_drops != 8'hFF) begin
            exp_drops++;         // Saturating drop count
        end
    endtask

    task automatic make_sample(input int line, input int idx, output imu_raw_t r);
        int         base;
        logic [1:0] flags;
        base = line * COLS;
        if (trace_mem[base+11][0]) begin  // Random payload
            r.roll   = 16'($random(seed));
            r.pitch  = 16'($random(seed));
            r.yaw    = 16'($random(seed));
            r.gyro_x = 16'($random(seed));
            r.gyro_y = 16'($random(seed));
            r.gyro_z = 16'($random(seed));
            flags    = 2'($random(seed));
        end else begin
            r.roll   = 16'(trace_mem[base+4] + 32'(idx));
            r.pitch  = 16'(trace_mem[base+5] + 32'(idx));
            r.yaw    = 16'(trace_mem[base+6] + 32'(idx));
            r.gyro_x = 16'(trace_mem[base+7] + 32'(idx));
            r.gyro_y = 16'(trace_mem[base+8] + 32'(idx));
            r.gyro_z = 16'(trace_mem[base+9] + 32'(idx));
            flags    = 2'(trace_mem[base+10]) ^ (idx[0] ? 2'b11 : 2'b00);  // Alternate
        end
        r.gyro_valid  = flags[1];
        r.euler_valid = flags[0];
    endtask

    task automatic drive_raw(input imu_raw_t r);
        roll          = r.roll;
        pitch         = r.pitch;
        yaw           = r.yaw;
        gyro_x        = r.gyro_x;
        gyro_y        = r.gyro_y;
        gyro_z        = r.gyro_z;
        euler_valid   = r.euler_valid;
        gyro_valid    = r.gyro_valid;
        sample_strobe = 1'b1;
    endtask

    // Called just after a clock fall
    task automatic reset_bridge();
        rst_n         = 1'b0;
        sample_strobe = 1'b0;
        repeat (3) @(negedge send_packet);
        rst_n = 1'b1;
        check_value("cs_n after reset", 32'(cs_n), 32'h1, main_errors);
        check_value("sck after reset", 32'(sck), 32'h0, main_errors);
        check_value("sdi after reset", 32'(sdi), 32'h0, main_errors);
        check_value("packet_sent after reset", 32'(packet_sent), 32'h0, main_errors);
        exp_seq   = 8'd0;
        exp_drops = 8'd0;
    endtask

    task automatic run_burst(input int line);
        imu_raw_t r;
        int       count;
        int       spacing;
        int       i;
        count   = int'(trace_mem[line*COLS+1]);
        spacing = int'(trace_mem[line*COLS+2]);
        if (trace_mem[line*COLS+3][0]) begin
            reset_bridge();
            repeat (100) @(negedge send_packet);
            check_value("frames before first strobe", 32'(frames_started),
                        32'(accepted_total), main_errors);
        end
        for (i = 0; i < count; i++) begin
            make_sample(line, i, r);
            @(negedge send_packet);
            drive_raw(r);
            model_capture(r);
            if (spacing > 1) begin
                @(negedge send_packet);
                sample_strobe = 1'b0;
                repeat (spacing - 2) @(negedge send_packet);
            end
        end
        @(negedge send_packet);
        sample_strobe = 1'b0;
        while (sent_cnt != accepted_total) @(negedge send_packet);  // Drain
        repeat (200) @(negedge send_packet);
        check_value("frames started", 32'(frames_started), 32'(accepted_total), main_errors);
        check_value("frames checked", 32'(frames_checked), 32'(accepted_total), main_errors);
    endtask

    task automatic report_test(input int tnum, input int err_base);
        int n;
        n = main_errors + mon_errors - err_base;
        if (n == 0) begin
            tests_ok++;
            $display("test %0d finished with no errors", tnum);
        end else begin
            tests_bad++;
            $display("test %0d finished with %0d errors", tnum, n);
        end
    endtask

    initial begin
        int line;
        int n_lines;
        int total_strobes;
        int cur_test;
        int err_base;
        rst_n         = 1'b0;
        sample_strobe = 1'b0;
        roll          = '0;
        pitch         = '0;
        yaw           = '0;
        gyro_x        = '0;
        gyro_y        = '0;
        gyro_z        = '0;
        euler_valid   = 1'b0;
        gyro_valid    = 1'b0;
        $readmemh("dv/imu_bridge_trace.txt", trace_mem);
        n_lines       = 0;
        total_strobes = 0;
        while (n_lines < MAX_LINES && !$isunknown(trace_mem[n_lines*COLS]) &&
               trace_mem[n_lines*COLS] != 32'h0) begin  // Test 0 ends the trace
            total_strobes += int'(trace_mem[n_lines*COLS+1]);
            n_lines++;
        end
        watch_cycles = 1200 * total_strobes + 20000;
        reset_bridge();
        repeat (50) @(negedge send_packet);
        check_value("frames after reset", 32'(frames_started), 32'h0, main_errors);
        cur_test = -1;
        err_base = 0;
        for (line = 0; line < n_lines; line++) begin
            if (int'(trace_mem[line*COLS]) != cur_test) begin
                if (cur_test >= 0) begin
                    report_test(cur_test, err_base);
                end
                cur_test = int'(trace_mem[line*COLS]);
                err_base = main_errors + mon_errors;
            end
            run_burst(line);
        end
        if (cur_test >= 0) begin
            report_test(cur_test, err_base);
        end
        $display("tests without errors: %0d, tests with errors: %0d, errors: %0d",
                 tests_ok, tests_bad, main_errors + mon_errors);
        if (main_errors + mon_errors == 0 && n_lines > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, budget set from the strobe count in the trace
    initial begin
        #1;
        repeat (watch_cycles) @(posedge send_packet);
        $display("timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* dv/imu_bridge_trace.txt */
// test count spacing reset roll pitch yaw gyro_x gyro_y gyro_z flags random
// All hex, flags bit 1 gyro_valid and bit 0 euler_valid, test 0 ends the trace
// Single sample into an idle bridge
1 1 1 0 0123 4567 89AB CDEF 8000 7FFF 3 0
// One more sample for frame timing
2 1 1 0 F00D 0FF0 1234 FEDC 0001 FFFF 1 0
// Five strobes 1000 cycles apart, each while a frame is in flight
3 5 3E8 0 1000 2000 3000 4000 5000 6000 2 0
// Eight back-to-back strobes, then a later sample carrying the drop count
4 8 1 0 0A00 0B00 0C00 0D00 0E00 0F00 0 0
4 1 1 0 7770 8880 9990 AAA0 BBB0 CCC0 3 0
// Reset, idle check, then one sample
5 1 1 1 1357 2468 369C 48C0 5A5A A5A5 1 0
// Sixteen random samples 1200 cycles apart
6 10 4B0 0 0 0 0 0 0 0 0 1
// End of trace
0 0 0 0 0 0 0 0 0 0 0 0

/* sources.f */
+incdir+design
design/imu_bridge_pkg.sv
design/sample_capture.sv
design/sample_queue.sv
design/spi_frame_tx.sv
design/imu_spi_bridge.sv
dv/imu_spi_bridge_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the IMU SPI bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing \
    --top-module imu_spi_bridge_tb \
    -f sources.f \
    -o imu_sim

./obj_dir/imu_sim | tee sim.log

# Pass only if the testbench printed its pass line
if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass line found in sim.log"
    exit 0
else
    echo "run_sim: pass line missing from sim.log"
    exit 1
fi
